// File: vram_stimulus.txt
# columns op addr data strb expected in hex with op W or R
# expected is checked on reads and shows the merged word on writes
W 0000 11223344 f 11223344
R 0000 00000000 0 11223344
W 0010 aabbccdd f aabbccdd
W 0010 00000099 1 aabbcc99
R 0010 00000000 0 aabbcc99
W 0010 55660000 c 5566cc99
R 0010 00000000 0 5566cc99
W 0010 0000ee00 2 5566ee99
W 0010 12345678 0 5566ee99
R 0012 00000000 0 5566ee99
W 0004 a5a5a5a5 f a5a5a5a5
W 1004 5a5a5a5a f 5a5a5a5a
W 2004 0f0f0f0f f 0f0f0f0f
W 3004 f0f0f0f0 f f0f0f0f0
W 3ffc deadbeef f deadbeef
W 2000 01020304 f 01020304
R 3ffc 00000000 0 deadbeef
R 0004 00000000 0 a5a5a5a5
R 2004 00000000 0 0f0f0f0f
R 1004 00000000 0 5a5a5a5a
R 2000 00000000 0 01020304
R 3004 00000000 0 f0f0f0f0
W 3ffc 00ff0000 4 deffbeef
W 2004 c3000000 8 c30f0f0f
R 3ffc 00000000 0 deffbeef
R 2004 00000000 0 c30f0f0f
R 0010 00000000 0 5566ee99
R 0000 00000000 0 11223344

// File: project.f
vram_pkg.sv
vram_dual_port.sv
axi_write_channel.sv
axi_read_channel.sv
vram_axi_ctrl.sv
tb_vram_axi_ctrl.sv

// File: Bender.yml
package:
  name: vram_axi_ctrl

sources:
  - vram_pkg.sv
  - vram_dual_port.sv
  - axi_write_channel.sv
  - axi_read_channel.sv
  - vram_axi_ctrl.sv
  - target: test
    files:
      - tb_vram_axi_ctrl.sv

// File: tb_vram_axi_ctrl.sv
`timescale 1ns/100ps

module tb_vram_axi_ctrl;

  localparam int addr_width = 14;
  // cycles any single wait may take before the run is aborted
  localparam int timeout_cycles = 40;
  // cycles from the accept cycle to BVALID
  localparam int b_latency = 4;

  logic                                S_AXI_ACLK;
  logic                                S_AXI_ARESETN;
  logic [addr_width-1:0]               s_axi_awaddr;
  logic                                s_axi_awvalid;
  logic                                s_axi_awready;
  logic [vram_pkg::data_width-1:0]     s_axi_wdata;
  logic [vram_pkg::strb_width-1:0]     s_axi_wstrb;
  logic                                s_axi_wvalid;
  logic                                s_axi_wready;
  logic [1:0]                          s_axi_bresp;
  logic                                s_axi_bvalid;
  logic                                s_axi_bready;
  logic [addr_width-1:0]               s_axi_araddr;
  logic                                s_axi_arvalid;
  logic                                s_axi_arready;
  logic [vram_pkg::data_width-1:0]     s_axi_rdata;
  logic [1:0]                          s_axi_rresp;
  logic                                s_axi_rvalid;
  logic                                s_axi_rready;

  // operation table with one entry per stimulus line
  byte           op_q[$];
  logic [31:0]   addr_q[$];
  logic [31:0]   data_q[$];
  logic [3:0]    strb_q[$];
  logic [31:0]   exp_q[$];

  int            errors;
  int unsigned   rng_state;
  // next operation was already put on the bus during a stall
  bit            write_presented;
  bit            read_presented;
  // a wait ran out and the remaining operations are skipped
  bit            timed_out;

  vram_axi_ctrl #(
    .addr_width (addr_width)
  ) vram_axi_ctrl_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
  );

  // 8 ns clock
  always #4 S_AXI_ACLK = ~S_AXI_ACLK;

  ////////////////////
  // helpers
  ////////////////////

  // drives and samples both happen 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch %s: expected %h, got %h", name, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic finish_run();
    $display("closing report: %0d operations, %0d errors", op_q.size(), errors);
    if (errors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic abort_timeout(input string what);
    report_failure({"timed out waiting for ", what});
    timed_out = 1;
  endtask

  // LCG step whose upper bits pick 0 to 3 stall cycles
  function automatic int pick_stall();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return int'((rng_state >> 16) % 4);
  endfunction

  task automatic read_stimulus();
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] expv;
    fd = $fopen("vram_stimulus.txt", "r");
    if (fd == 0)
    begin
      report_failure("could not open vram_stimulus.txt");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      // comment and blank lines carry no operation
      if (line.len() < 2 || line.getc(0) == "#")
      begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h %h", op, addr, data, strb, expv);
      if (n != 5)
      begin
        report_failure({"malformed stimulus line ", line});
      end
      else
      begin
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        strb_q.push_back(strb);
        exp_q.push_back(expv);
      end
    end
    $fclose(fd);
  endtask

  // all five ready/valid outputs must be low
  task automatic check_idle(input string phase);
    logic [4:0] flags;
    flags = {s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_arready, s_axi_rvalid};
    if (flags !== 5'b0)
    begin
      report_mismatch({"{awready,wready,bvalid,arready,rvalid} ", phase}, 0, flags);
    end
  endtask

  ////////////////////
  // bus operations
  ////////////////////

  task automatic present_write(input int idx);
    s_axi_awaddr  = addr_q[idx][addr_width-1:0];
    s_axi_wdata   = data_q[idx];
    s_axi_wstrb   = strb_q[idx];
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
  endtask

  task automatic present_read(input int idx);
    s_axi_araddr  = addr_q[idx][addr_width-1:0];
    s_axi_arvalid = 1'b1;
  endtask

  task automatic do_write(input int idx);
    int n;
    int k;
    int stall;
    if (!write_presented)
    begin
      present_write(idx);
    end
    write_presented = 0;
    // wait for the accept cycle
    n = 0;
    next_cycle();
    while (s_axi_awready !== 1'b1)
    begin
      n++;
      if (n > timeout_cycles)
      begin
        abort_timeout("AWREADY");
        return;
      end
      next_cycle();
    end
    if (s_axi_wready !== 1'b1)
    begin
      report_mismatch("s_axi_wready in accept cycle", 1, s_axi_wready);
    end
    // both transfers happen on this edge and the readies must drop after one cycle
    next_cycle();
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    if ({s_axi_awready, s_axi_wready} !== 2'b00)
    begin
      report_mismatch("{s_axi_awready,s_axi_wready} after accept", 0,
                      {s_axi_awready, s_axi_wready});
    end
    // n counts cycles since the accept cycle
    n = 1;
    while (s_axi_bvalid !== 1'b1)
    begin
      if (n > timeout_cycles)
      begin
        abort_timeout("BVALID");
        return;
      end
      next_cycle();
      n++;
    end
    if (n != b_latency)
    begin
      report_mismatch("BVALID latency in cycles", b_latency, n);
    end
    if (s_axi_bresp !== vram_pkg::resp_okay)
    begin
      report_mismatch("s_axi_bresp", vram_pkg::resp_okay, s_axi_bresp);
    end
    // a following write waits on the bus while BREADY is stalled
    stall = pick_stall();
    if (stall > 0 && idx + 1 < op_q.size() && op_q[idx + 1] == "W")
    begin
      present_write(idx + 1);
      write_presented = 1;
    end
    for (k = 0; k < stall; k++)
    begin
      next_cycle();
      if (s_axi_bvalid !== 1'b1)
      begin
        report_mismatch("s_axi_bvalid during stall", 1, s_axi_bvalid);
      end
      if (s_axi_awready !== 1'b0)
      begin
        report_failure("AWREADY rose while a write response was pending");
      end
    end
    s_axi_bready = 1'b1;
    next_cycle();
    s_axi_bready = 1'b0;
  endtask

  task automatic do_read(input int idx);
    int          n;
    int          k;
    int          stall;
    logic [31:0] held;
    if (!read_presented)
    begin
      present_read(idx);
    end
    read_presented = 0;
    n = 0;
    next_cycle();
    while (s_axi_arready !== 1'b1)
    begin
      n++;
      if (n > timeout_cycles)
      begin
        abort_timeout("ARREADY");
        return;
      end
      next_cycle();
    end
    // AR transfer on this edge
    next_cycle();
    s_axi_arvalid = 1'b0;
    n = 0;
    while (s_axi_rvalid !== 1'b1)
    begin
      n++;
      if (n > timeout_cycles)
      begin
        abort_timeout("RVALID");
        return;
      end
      next_cycle();
    end
    if (s_axi_rdata !== exp_q[idx])
    begin
      report_mismatch("s_axi_rdata", exp_q[idx], s_axi_rdata);
    end
    if (s_axi_rresp !== vram_pkg::resp_okay)
    begin
      report_mismatch("s_axi_rresp", vram_pkg::resp_okay, s_axi_rresp);
    end
    // word and valid must hold while RREADY is stalled
    held = s_axi_rdata;
    stall = pick_stall();
    if (stall > 0 && idx + 1 < op_q.size() && op_q[idx + 1] == "R")
    begin
      present_read(idx + 1);
      read_presented = 1;
    end
    for (k = 0; k < stall; k++)
    begin
      next_cycle();
      if (s_axi_rvalid !== 1'b1)
      begin
        report_mismatch("s_axi_rvalid during stall", 1, s_axi_rvalid);
      end
      if (s_axi_rdata !== held)
      begin
        report_mismatch("s_axi_rdata during stall", held, s_axi_rdata);
      end
      if (s_axi_arready !== 1'b0)
      begin
        report_failure("ARREADY rose while read data was pending");
      end
    end
    s_axi_rready = 1'b1;
    next_cycle();
    s_axi_rready = 1'b0;
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    int k;
    S_AXI_ACLK      = 1'b0;
    S_AXI_ARESETN   = 1'b0;
    s_axi_awaddr    = '0;
    s_axi_awvalid   = 1'b0;
    s_axi_wdata     = '0;
    s_axi_wstrb     = '0;
    s_axi_wvalid    = 1'b0;
    s_axi_bready    = 1'b0;
    s_axi_araddr    = '0;
    s_axi_arvalid   = 1'b0;
    s_axi_rready    = 1'b0;
    errors          = 0;
    rng_state       = 62407;
    write_presented = 0;
    read_presented  = 0;
    timed_out       = 0;
    read_stimulus();
    if (op_q.size() == 0)
    begin
      report_failure("stimulus file holds no operations");
    end
    // outputs are checked on each of the 5 reset cycles
    repeat (5)
    begin
      next_cycle();
      check_idle("during reset");
    end
    S_AXI_ARESETN = 1'b1;
    next_cycle();
    check_idle("after reset");
    for (k = 0; k < op_q.size() && !timed_out; k++)
    begin
      if (op_q[k] == "W")
      begin
        do_write(k);
      end
      else if (op_q[k] == "R")
      begin
        do_read(k);
      end
      else
      begin
        report_failure("unknown operation letter in stimulus file");
      end
    end
    next_cycle();
    finish_run();
  end

endmodule

// File: vram_axi_ctrl.sv
`timescale 1ns/100ps

module vram_axi_ctrl #(
  // byte address width where 14 gives 4096 words
  parameter int addr_width = 14,
  localparam int index_width = addr_width - vram_pkg::addr_lsb
)
(
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  // write address
  input  logic [addr_width-1:0]               s_axi_awaddr,
  input  logic                                s_axi_awvalid,
  output logic                                s_axi_awready,
  // write data
  input  logic [vram_pkg::data_width-1:0]     s_axi_wdata,
  input  logic [vram_pkg::strb_width-1:0]     s_axi_wstrb,
  input  logic                                s_axi_wvalid,
  output logic                                s_axi_wready,
  // write response
  output logic [1:0]                          s_axi_bresp,
  output logic                                s_axi_bvalid,
  input  logic                                s_axi_bready,
  // read address
  input  logic [addr_width-1:0]               s_axi_araddr,
  input  logic                                s_axi_arvalid,
  output logic                                s_axi_arready,
  // read data
  output logic [vram_pkg::data_width-1:0]     s_axi_rdata,
  output logic [1:0]                          s_axi_rresp,
  output logic                                s_axi_rvalid,
  input  logic                                s_axi_rready
);

  ////////////////////
  // internal wiring
  ////////////////////

  // W channel beat as seen by the write side
  vram_pkg::vram_wdata_t w_payload;

  // RAM write port
  logic                              wr_en;
  logic [index_width-1:0]            wr_index;
  vram_pkg::vram_wdata_t             wr_payload;

  // RAM read port
  logic                              rd_en;
  logic [index_width-1:0]            rd_index;
  logic [vram_pkg::data_width-1:0]   rd_word;

  assign w_payload = '{data: s_axi_wdata, strb: s_axi_wstrb};

  ////////////////////
  // write side
  ////////////////////

  axi_write_channel #(
    .addr_width (addr_width)
  ) axi_write_channel_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wvalid        (s_axi_wvalid),
    .wpayload      (w_payload),
    .wready        (s_axi_wready),
    .bvalid        (s_axi_bvalid),
    .bresp         (s_axi_bresp),
    .bready        (s_axi_bready),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_payload    (wr_payload)
  );

  ////////////////////
  // read side
  ////////////////////

  axi_read_channel #(
    .addr_width (addr_width)
  ) axi_read_channel_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rvalid        (s_axi_rvalid),
    .rresp         (s_axi_rresp),
    .rdata         (s_axi_rdata),
    .rready        (s_axi_rready),
    .rd_en         (rd_en),
    .rd_index      (rd_index),
    .rd_word       (rd_word)
  );

  ////////////////////
  // video RAM
  ////////////////////

  // independent ports so write side and read side never contend
  vram_dual_port #(
    .addr_width (addr_width)
  ) vram_dual_port_i (
    .S_AXI_ACLK (S_AXI_ACLK),
    .wr_en      (wr_en),
    .wr_index   (wr_index),
    .wr_payload (wr_payload),
    .rd_en      (rd_en),
    .rd_index   (rd_index),
    .rd_word    (rd_word)
  );

endmodule

// File: axi_read_channel.sv
`timescale 1ns/100ps

module axi_read_channel #(
  // byte address width of the AXI bus
  parameter int addr_width = 14,
  localparam int index_width = addr_width - vram_pkg::addr_lsb
)
(
  input  logic                              S_AXI_ACLK,
  input  logic                              S_AXI_ARESETN,
  // AR channel
  input  logic [addr_width-1:0]             araddr,
  input  logic                              arvalid,
  output logic                              arready,
  // R channel
  output logic                              rvalid,
  output vram_pkg::resp_t                   rresp,
  output logic [vram_pkg::data_width-1:0]   rdata,
  input  logic                              rready,
  // RAM read port
  output logic                              rd_en,
  output logic [index_width-1:0]            rd_index,
  input  logic [vram_pkg::data_width-1:0]   rd_word
);

  ////////////////////
  // internal signals
  ////////////////////

  // decision to raise ARREADY on the coming edge
  logic ar_accept;
  // latched word index of the accepted read
  logic [index_width-1:0] ar_index_q;

  ////////////////////
  // address channel
  ////////////////////

  // one read in flight and nothing new while data is pending
  assign ar_accept = arvalid && !arready && !rvalid;

  // single-cycle ARREADY pulse
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready <= 1'b0;
    end
    else
    begin
      arready <= ar_accept;
    end
  end

  // latch the word index together with ARREADY
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (ar_accept)
    begin
      ar_index_q <= araddr[addr_width-1:vram_pkg::addr_lsb];
    end
  end

  ////////////////////
  // RAM request
  ////////////////////

  // AR transfer edge also reads the RAM
  assign rd_en    = arready && arvalid;
  assign rd_index = ar_index_q;

  ////////////////////
  // data channel
  ////////////////////

  // RVALID comes up with the RAM output register
  // and drops once the master takes the word
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      rvalid <= 1'b0;
    end
    else if (rd_en)
    begin
      rvalid <= 1'b1;
    end
    else if (rvalid && rready)
    begin
      rvalid <= 1'b0;
    end
  end

  // RAM output holds while rd_en is low so RDATA stays stable under a stall
  assign rdata = rd_word;
  assign rresp = vram_pkg::resp_okay;

endmodule

// File: axi_write_channel.sv
`timescale 1ns/100ps

module axi_write_channel #(
  // byte address width of the AXI bus
  parameter int addr_width = 14,
  localparam int index_width = addr_width - vram_pkg::addr_lsb
)
(
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // AW channel
  input  logic [addr_width-1:0]    awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  // W channel with data and strobes packed
  input  logic                     wvalid,
  input  vram_pkg::vram_wdata_t    wpayload,
  output logic                     wready,
  // B channel
  output logic                     bvalid,
  output vram_pkg::resp_t          bresp,
  input  logic                     bready,
  // RAM write port
  output logic                     wr_en,
  output logic [index_width-1:0]   wr_index,
  output vram_pkg::vram_wdata_t    wr_payload
);

  ////////////////////
  // internal signals
  ////////////////////

  // high from acceptance until the B transfer completes
  logic aw_busy;
  // shared ready pulse for AW and W
  logic accept_q;
  // decision to accept on the coming edge
  logic aw_accept;
  // AW and W transfers both happen this cycle
  logic wr_fire;
  // B transfer happens this cycle
  logic b_done;
  // latched word index of the accepted write
  logic [index_width-1:0] aw_index_q;

  vram_pkg::wr_state_t wr_state;
  vram_pkg::wr_state_t wr_state_next;

  ////////////////////
  // handshake decode
  ////////////////////

  // both address and data must be present with at most one write outstanding
  assign aw_accept = awvalid && wvalid && !aw_busy;
  assign wr_fire   = accept_q && awvalid && wvalid;
  assign b_done    = bvalid && bready;

  // AW and W are always taken together
  assign awready = accept_q;
  assign wready  = accept_q;

  // ready pulse lasts one cycle as aw_busy blocks the next one
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      accept_q <= 1'b0;
    end
    else
    begin
      accept_q <= aw_accept;
    end
  end

  // outstanding write flag
  // cleared only once the master has taken the response
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      aw_busy <= 1'b0;
    end
    else if (aw_accept)
    begin
      aw_busy <= 1'b1;
    end
    else if (b_done)
    begin
      aw_busy <= 1'b0;
    end
  end

  // address latch keeping the word index bits only
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (aw_accept)
    begin
      aw_index_q <= awaddr[addr_width-1:vram_pkg::addr_lsb];
    end
  end

  ////////////////////
  // RAM write port
  ////////////////////

  // RAM is written on the edge that ends the accept cycle
  // payload is taken straight off the bus since it is stable while valid
  assign wr_en      = wr_fire;
  assign wr_index   = aw_index_q;
  assign wr_payload = wpayload;

  ////////////////////
  // response delay FSM
  ////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      wr_state <= vram_pkg::wr_idle;
    end
    else
    begin
      wr_state <= wr_state_next;
    end
  end

  // idle then three wait states then back to idle
  always_comb
  begin
    wr_state_next = wr_state;
    case (wr_state)
      vram_pkg::wr_idle:
      begin
        if (wr_fire)
        begin
          wr_state_next = vram_pkg::wr_wait_1;
        end
      end
      vram_pkg::wr_wait_1: wr_state_next = vram_pkg::wr_wait_2;
      vram_pkg::wr_wait_2: wr_state_next = vram_pkg::wr_wait_3;
      vram_pkg::wr_wait_3: wr_state_next = vram_pkg::wr_idle;
      default:             wr_state_next = vram_pkg::wr_idle;
    endcase
  end

  // BVALID goes up as wait_3 ends four cycles after accept
  // then holds until BREADY
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      bvalid <= 1'b0;
    end
    else if (wr_state == vram_pkg::wr_wait_3)
    begin
      bvalid <= 1'b1;
    end
    else if (b_done)
    begin
      bvalid <= 1'b0;
    end
  end

  // every write completes normally
  assign bresp = vram_pkg::resp_okay;

endmodule

// File: vram_dual_port.sv
`timescale 1ns/100ps

module vram_dual_port #(
  // byte address width that sets the word index width
  parameter int addr_width = 14,
  localparam int index_width = addr_width - vram_pkg::addr_lsb
)
(
  input  logic                              S_AXI_ACLK,
  // byte strobed write port
  input  logic                              wr_en,
  input  logic [index_width-1:0]            wr_index,
  input  vram_pkg::vram_wdata_t             wr_payload,
  // read port with registered output
  input  logic                              rd_en,
  input  logic [index_width-1:0]            rd_index,
  output logic [vram_pkg::data_width-1:0]   rd_word
);

  // number of words in the array
  localparam int depth = 2 ** index_width;

  ////////////////////
  // storage
  ////////////////////

  // contents are undefined until written
  logic [vram_pkg::data_width-1:0] mem [0:depth-1];

  ////////////////////
  // write port
  ////////////////////

  // only lanes with their strobe bit set are updated
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (wr_en)
    begin
      for (int lane = 0; lane < vram_pkg::strb_width; lane++)
      begin
        if (wr_payload.strb[lane])
        begin
          mem[wr_index][lane*8 +: 8] <= wr_payload.data[lane*8 +: 8];
        end
      end
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // word is captured on the rd_en edge and then held
  // a same-cycle write to this word is not seen so old contents come out
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (rd_en)
    begin
      rd_word <= mem[rd_index];
    end
  end

endmodule

// File: vram_pkg.sv
package vram_pkg;

  ////////////////////
  // bus geometry
  ////////////////////

  // data bus and memory word width
  localparam int data_width = 32;
  // one strobe bit per byte lane
  localparam int strb_width = data_width / 8;
  // lowest byte-address bit that selects a word
  localparam int addr_lsb = 2;

  ////////////////////
  // AXI response codes
  ////////////////////

  // only okay is ever returned by this slave
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_t;

  ////////////////////
  // write response FSM
  ////////////////////

  // fixed three-cycle hold before BVALID is raised
  typedef enum logic [1:0] {
    wr_idle,
    wr_wait_1,
    wr_wait_2,
    wr_wait_3
  } wr_state_t;

  // word data plus byte strobes of one write beat
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
  } vram_wdata_t;

endpackage
